//--- dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int NUM_TESTS = 5;

    logic               clk;
    logic               reset_n;
    cpu_isa_pkg::word_t data1;
    logic               m1_ack;
    logic               read_m1;
    cpu_isa_pkg::word_t address1;
    cpu_isa_pkg::word_t num_inst;
    cpu_isa_pkg::word_t output_port;
    logic               is_halted;

    // Test table
    cpu_isa_pkg::word_t prog      [NUM_TESTS][16];
    int                 prog_len  [NUM_TESTS];
    cpu_isa_pkg::word_t exp_wwd   [NUM_TESTS][4];  // Values shown by WWD, in order
    int                 exp_wwd_n [NUM_TESTS];
    cpu_isa_pkg::word_t exp_num   [NUM_TESTS];
    string              test_name [NUM_TESTS];

    cpu_isa_pkg::word_t seen [$];
    int                 pass_cnt;
    int                 fail_cnt;

    cpu_top #(.RESET_PC(16'h0000)) u_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .data1       (data1),
        .m1_ack      (m1_ack),
        .read_m1     (read_m1),
        .address1    (address1),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    inst_memory_model u_mem (
        .clk      (clk),
        .read_m1  (read_m1),
        .address1 (address1),
        .data1    (data1),
        .m1_ack   (m1_ack)
    );

    always #50 clk = ~clk;

    // Log every new output_port value while running
    always @(output_port) begin
        if (reset_n === 1'b0) begin
            seen.push_back(output_port);
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Instruction encoding and table building
    ////////////////////////////////////////////////////////////////////

    function automatic cpu_isa_pkg::word_t imm_inst(input cpu_isa_pkg::opcode_e op,
                                                    input logic [1:0] rs,
                                                    input logic [1:0] rt,
                                                    input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic cpu_isa_pkg::word_t reg_inst(input cpu_isa_pkg::funct_e fn,
                                                    input logic [1:0] rs,
                                                    input logic [1:0] rt,
                                                    input logic [1:0] rd);
        return {cpu_isa_pkg::RTYPE, rs, rt, rd, fn};
    endfunction

    task automatic put_inst(input int t, input cpu_isa_pkg::word_t w);
        prog[t][prog_len[t]] = w;
        prog_len[t] = prog_len[t] + 1;
    endtask

    task automatic set_expect(input int t, input string name, input cpu_isa_pkg::word_t num,
                              input int n, input cpu_isa_pkg::word_t w0,
                              input cpu_isa_pkg::word_t w1, input cpu_isa_pkg::word_t w2,
                              input cpu_isa_pkg::word_t w3);
        test_name[t]  = name;
        exp_num[t]    = num;
        exp_wwd_n[t]  = n;
        exp_wwd[t][0] = w0;
        exp_wwd[t][1] = w1;
        exp_wwd[t][2] = w2;
        exp_wwd[t][3] = w3;
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t] = 0;
        end
        // r1 = 0x35, r2 = 0x1c
        put_inst(0, imm_inst(cpu_isa_pkg::ADI, 0, 1, 8'h35));
        put_inst(0, imm_inst(cpu_isa_pkg::ADI, 0, 2, 8'h1c));
        put_inst(0, reg_inst(cpu_isa_pkg::ADD, 1, 2, 3));
        put_inst(0, reg_inst(cpu_isa_pkg::WWD, 3, 0, 0));
        put_inst(0, reg_inst(cpu_isa_pkg::SUB, 1, 2, 3));
        put_inst(0, reg_inst(cpu_isa_pkg::WWD, 3, 0, 0));
        put_inst(0, reg_inst(cpu_isa_pkg::AND, 1, 2, 3));
        put_inst(0, reg_inst(cpu_isa_pkg::WWD, 3, 0, 0));
        put_inst(0, reg_inst(cpu_isa_pkg::ORR, 1, 2, 3));
        put_inst(0, reg_inst(cpu_isa_pkg::WWD, 3, 0, 0));
        put_inst(0, reg_inst(cpu_isa_pkg::HLT, 0, 0, 0));
        set_expect(0, "r-type arithmetic", 16'd11, 4, 16'h0051, 16'h0019, 16'h0014, 16'h003d);

        put_inst(1, imm_inst(cpu_isa_pkg::LHI, 0, 1, 8'ha5));
        put_inst(1, imm_inst(cpu_isa_pkg::ORI, 1, 1, 8'h3c));
        put_inst(1, reg_inst(cpu_isa_pkg::WWD, 1, 0, 0));
        put_inst(1, imm_inst(cpu_isa_pkg::ADI, 1, 2, 8'hf0));  // Minus 16
        put_inst(1, reg_inst(cpu_isa_pkg::WWD, 2, 0, 0));
        put_inst(1, imm_inst(cpu_isa_pkg::ORI, 0, 3, 8'h80));  // No sign extension
        put_inst(1, reg_inst(cpu_isa_pkg::WWD, 3, 0, 0));
        put_inst(1, reg_inst(cpu_isa_pkg::HLT, 0, 0, 0));
        set_expect(1, "immediates", 16'd8, 3, 16'ha53c, 16'ha52c, 16'h0080, 16'h0000);

        // r1 = 0x8106
        put_inst(2, imm_inst(cpu_isa_pkg::LHI, 0, 1, 8'h81));
        put_inst(2, imm_inst(cpu_isa_pkg::ORI, 1, 1, 8'h06));
        put_inst(2, reg_inst(cpu_isa_pkg::NOT, 1, 0, 2));
        put_inst(2, reg_inst(cpu_isa_pkg::WWD, 2, 0, 0));
        put_inst(2, reg_inst(cpu_isa_pkg::TCP, 1, 0, 2));
        put_inst(2, reg_inst(cpu_isa_pkg::WWD, 2, 0, 0));
        put_inst(2, reg_inst(cpu_isa_pkg::SHL, 1, 0, 2));
        put_inst(2, reg_inst(cpu_isa_pkg::WWD, 2, 0, 0));
        put_inst(2, reg_inst(cpu_isa_pkg::SHR, 1, 0, 2));
        put_inst(2, reg_inst(cpu_isa_pkg::WWD, 2, 0, 0));
        put_inst(2, reg_inst(cpu_isa_pkg::HLT, 0, 0, 0));
        set_expect(2, "unary ops", 16'd11, 4, 16'h7ef9, 16'h7efa, 16'h020c, 16'h4083);

        put_inst(3, imm_inst(cpu_isa_pkg::ADI, 0, 1, 8'h05));
        put_inst(3, imm_inst(cpu_isa_pkg::ADI, 0, 2, 8'h05));
        put_inst(3, imm_inst(cpu_isa_pkg::BEQ, 1, 2, 8'h01));  // Taken
        put_inst(3, imm_inst(cpu_isa_pkg::ADI, 1, 1, 8'h10));
        put_inst(3, imm_inst(cpu_isa_pkg::BNE, 1, 2, 8'h01));  // Falls through
        put_inst(3, imm_inst(cpu_isa_pkg::ADI, 0, 3, 8'h07));
        put_inst(3, imm_inst(cpu_isa_pkg::BNE, 3, 1, 8'h01));  // Taken
        put_inst(3, imm_inst(cpu_isa_pkg::ADI, 3, 3, 8'h01));
        put_inst(3, reg_inst(cpu_isa_pkg::ADD, 3, 1, 3));
        put_inst(3, reg_inst(cpu_isa_pkg::WWD, 3, 0, 0));
        put_inst(3, reg_inst(cpu_isa_pkg::HLT, 0, 0, 0));
        set_expect(3, "branches", 16'd9, 1, 16'h000c, 16'h0000, 16'h0000, 16'h0000);

        put_inst(4, imm_inst(cpu_isa_pkg::ADI, 0, 1, 8'h22));
        put_inst(4, imm_inst(cpu_isa_pkg::JMP, 0, 0, 8'h05));
        put_inst(4, imm_inst(cpu_isa_pkg::ADI, 1, 1, 8'h01));
        put_inst(4, imm_inst(cpu_isa_pkg::ADI, 1, 1, 8'h01));
        put_inst(4, reg_inst(cpu_isa_pkg::WWD, 1, 0, 0));
        put_inst(4, 16'h2fff);  // Unknown opcode
        put_inst(4, imm_inst(cpu_isa_pkg::ADI, 1, 1, 8'h11));
        put_inst(4, reg_inst(cpu_isa_pkg::WWD, 1, 0, 0));
        put_inst(4, reg_inst(cpu_isa_pkg::HLT, 0, 0, 0));
        set_expect(4, "jump and no-op", 16'd6, 1, 16'h0033, 16'h0000, 16'h0000, 16'h0000);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Running one test
    ////////////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic load_memory(input int t);
        for (int a = 0; a < 64; a++) begin
            if (a < prog_len[t]) begin
                u_mem.mem[a] = prog[t][a];
            end else begin
                u_mem.mem[a] = 16'h9000 | 16'(a);  // Self-jump traps runaway code
            end
        end
    endtask

    task automatic run_test(input int t);
        int                 cycles;
        int                 errs;
        cpu_isa_pkg::word_t held_num;
        cpu_isa_pkg::word_t held_out;
        errs = 0;
        reset_n = 1'b1;
        load_memory(t);
        seen.delete();
        repeat (3) step();
        if (read_m1 !== 1'b0 || num_inst !== 16'd0 || output_port !== 16'd0
            || is_halted !== 1'b0 || address1 !== 16'h0000) begin
            $display("MISMATCH at %0t: test %0d in reset read_m1=%b num=%h out=%h halt=%b pc=%h",
                     $time, t, read_m1, num_inst, output_port, is_halted, address1);
            errs++;
        end
        reset_n = 1'b0;
        cycles = 0;
        while (is_halted !== 1'b1 && cycles < 2000) begin
            step();
            cycles++;
        end
        if (is_halted !== 1'b1) begin
            $display("Test %0d timed out: the core did not halt within 2000 cycles", t);
            errs++;
        end else begin
            if (num_inst !== exp_num[t]) begin
                $display("MISMATCH at %0t: test %0d num_inst %h, expected %h",
                         $time, t, num_inst, exp_num[t]);
                errs++;
            end
            if (seen.size() != exp_wwd_n[t]) begin
                $display("MISMATCH at %0t: test %0d saw %0d WWD values, expected %0d",
                         $time, t, seen.size(), exp_wwd_n[t]);
                errs++;
            end else begin
                for (int i = 0; i < exp_wwd_n[t]; i++) begin
                    if (seen[i] !== exp_wwd[t][i]) begin
                        $display("MISMATCH at %0t: test %0d WWD %0d is %h, expected %h",
                                 $time, t, i, seen[i], exp_wwd[t][i]);
                        errs++;
                    end
                end
            end
            if (output_port !== exp_wwd[t][exp_wwd_n[t] - 1]) begin
                $display("MISMATCH at %0t: test %0d output_port %h, expected %h",
                         $time, t, output_port, exp_wwd[t][exp_wwd_n[t] - 1]);
                errs++;
            end
            // Halted core must stay frozen
            held_num = num_inst;
            held_out = output_port;
            for (int i = 0; i < 20; i++) begin
                step();
                if (read_m1 !== 1'b0 || num_inst !== held_num || output_port !== held_out) begin
                    $display("MISMATCH at %0t: test %0d moved after halt read_m1=%b num=%h out=%h",
                             $time, t, read_m1, num_inst, output_port);
                    errs++;
                    break;
                end
            end
        end
        $display("Test %0d %s: %s", t, test_name[t], (errs == 0) ? "ok" : "failed");
        if (errs == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
    endtask

    initial begin
        clk      = 1'b0;
        reset_n  = 1'b1;
        pass_cnt = 0;
        fail_cnt = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests run %0d, passed %0d, failed %0d", NUM_TESTS, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- dv/inst_memory_model.sv
`timescale 1ns/1ps

module inst_memory_model (
    input  logic               clk,
    input  logic               read_m1,
    input  cpu_isa_pkg::word_t address1,
    output cpu_isa_pkg::word_t data1,
    output logic               m1_ack
);

    cpu_isa_pkg::word_t mem [64];  // Filled by the testbench
    integer             seed;
    integer             wait_left;
    logic               pending;

    initial begin
        seed      = 32'h555e8adf;
        pending   = 1'b0;
        wait_left = 0;
        m1_ack    = 1'b0;
        data1     = '0;
    end

    // Ack lands 1 to 4 cycles after read_m1 rises and lasts one cycle
    always @(posedge clk) begin
        #1;
        if (!read_m1 || m1_ack) begin
            pending = 1'b0;
            m1_ack  = 1'b0;
            data1   = '0;
        end else if (!pending) begin
            pending   = 1'b1;
            wait_left = 1 + (($random(seed) & 32'h7fff_ffff) % 4);
        end else begin
            wait_left = wait_left - 1;
            if (wait_left == 0) begin
                pending = 1'b0;
                m1_ack  = 1'b1;
                data1   = mem[address1[5:0]];
            end
        end
    end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_isa_pkg::word_t        read_data_1,
    input  cpu_isa_pkg::word_t        read_data_2,
    input  cpu_ctrl_pkg::ctrl_t       ctrl,
    input  cpu_isa_pkg::inst_fields_t fields,
    output cpu_isa_pkg::word_t        result,
    output logic                      is_zero
);

    cpu_isa_pkg::word_t imm_ext;
    cpu_isa_pkg::word_t op_b;

    // 8-bit immediate, extended per opcode
    assign imm_ext = ctrl.imm_zero_ext ? {8'h00, fields[7:0]}
                                       : {{8{fields[7]}}, fields[7:0]};
    assign op_b    = ctrl.alu_src_imm ? imm_ext : read_data_2;

    always_comb begin
        case (ctrl.alu_op)
            cpu_ctrl_pkg::OP_ADD: result = read_data_1 + op_b;
            cpu_ctrl_pkg::OP_SUB: result = read_data_1 - op_b;
            cpu_ctrl_pkg::OP_AND: result = read_data_1 & op_b;
            cpu_ctrl_pkg::OP_OR:  result = read_data_1 | op_b;
            cpu_ctrl_pkg::OP_NOT: result = ~read_data_1;
            cpu_ctrl_pkg::OP_TCP: result = ~read_data_1 + 16'd1;
            cpu_ctrl_pkg::OP_SHL: result = {read_data_1[14:0], 1'b0};
            cpu_ctrl_pkg::OP_SHR: result = {1'b0, read_data_1[15:1]};  // Logical
            cpu_ctrl_pkg::OP_LHI: result = {op_b[7:0], 8'h00};
            default:              result = '0;
        endcase
    end

    assign is_zero = (result == 16'h0000);

endmodule

//--- source/arch_state.sv
`timescale 1ns/1ps

module arch_state (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      exec_en,
    input  cpu_ctrl_pkg::ctrl_t       ctrl,
    input  cpu_isa_pkg::inst_fields_t fields,
    input  cpu_isa_pkg::word_t        result,
    output cpu_isa_pkg::word_t        read_data_1,
    output cpu_isa_pkg::word_t        read_data_2,
    output cpu_isa_pkg::word_t        output_port
);

    cpu_isa_pkg::word_t    regs [4];
    cpu_isa_pkg::reg_addr_t wr_addr;

    assign wr_addr = ctrl.dest_rd ? fields.rd : fields.rt;

    // Combinational read ports
    assign read_data_1 = regs[fields.rs];
    assign read_data_2 = regs[fields.rt];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            regs        <= '{default: '0};
            output_port <= '0;
        end else if (exec_en) begin
            if (ctrl.reg_write) begin
                regs[wr_addr] <= result;
            end
            if (ctrl.is_wwd) begin
                output_port <= read_data_1;  // WWD shows rs
            end
        end
    end

endmodule

//--- source/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // Sequencer states
    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        HALTED
    } state_e;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_NOT,
        OP_TCP,
        OP_SHL,
        OP_SHR,
        OP_LHI
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;     // B operand from immediate
        logic    imm_zero_ext;
        logic    reg_write;
        logic    dest_rd;         // Write rd, else rt
        logic    is_wwd;
        logic    is_halt;
        logic    is_jump;
        logic    is_branch;
        logic    branch_on_equal;
    } ctrl_t;

endpackage

//--- source/cpu_fsm.sv
`timescale 1ns/1ps

module cpu_fsm (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 m1_ack,
    input  cpu_ctrl_pkg::ctrl_t  ctrl,
    output logic                 read_m1,
    output logic                 ir_load,
    output logic                 exec_en,
    output logic                 is_halted
);

    cpu_ctrl_pkg::state_e state;
    logic                 fetch_req;  // Registered fetch strobe

    ////////////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state     <= cpu_ctrl_pkg::FETCH;
            fetch_req <= 1'b0;
        end else begin
            case (state)
                cpu_ctrl_pkg::FETCH: begin
                    if (fetch_req && m1_ack) begin
                        state     <= cpu_ctrl_pkg::EXECUTE;
                        fetch_req <= 1'b0;
                    end else begin
                        fetch_req <= 1'b1;   // Hold until memory answers
                    end
                end
                cpu_ctrl_pkg::EXECUTE: begin
                    if (ctrl.is_halt) begin
                        state     <= cpu_ctrl_pkg::HALTED;
                        fetch_req <= 1'b0;
                    end else begin
                        state     <= cpu_ctrl_pkg::FETCH;
                        fetch_req <= 1'b1;
                    end
                end
                default: begin
                    // Parked until reset
                    state     <= cpu_ctrl_pkg::HALTED;
                    fetch_req <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////

    assign read_m1   = fetch_req;
    assign ir_load   = fetch_req & m1_ack;  // Capture in the ack cycle
    assign exec_en   = (state == cpu_ctrl_pkg::EXECUTE);
    assign is_halted = (state == cpu_ctrl_pkg::HALTED);

endmodule

//--- source/cpu_isa_pkg.sv
package cpu_isa_pkg;

    ////////////////////////////////////////////////////////////////////
    // Basic word types
    ////////////////////////////////////////////////////////////////////

    typedef logic [15:0] word_t;      // Data, address and instruction
    typedef logic [1:0]  reg_addr_t;  // r0 .. r3

    ////////////////////////////////////////////////////////////////////
    // Opcode and function codes
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        BNE   = 4'd0,
        BEQ   = 4'd1,
        ADI   = 4'd4,
        ORI   = 4'd5,
        LHI   = 4'd6,
        JMP   = 4'd9,
        RTYPE = 4'd15
    } opcode_e;

    // Only meaningful when the opcode is RTYPE
    typedef enum logic [5:0] {
        ADD = 6'd0,
        SUB = 6'd1,
        AND = 6'd2,
        ORR = 6'd3,
        NOT = 6'd4,
        TCP = 6'd5,
        SHL = 6'd6,
        SHR = 6'd7,
        WWD = 6'd28,
        HLT = 6'd29
    } funct_e;

    // Field view of an instruction word
    // Immediate sits in [7:0] and jump target in [11:0] of the packed view
    typedef struct packed {
        opcode_e   opcode;  // [15:12]
        reg_addr_t rs;      // [11:10]
        reg_addr_t rt;      // [9:8]
        reg_addr_t rd;      // [7:6]
        funct_e    funct;   // [5:0]
    } inst_fields_t;

endpackage

//--- source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter cpu_isa_pkg::word_t RESET_PC = 16'h0000
) (
    input  logic               clk,
    input  logic               reset_n,
    input  cpu_isa_pkg::word_t data1,
    input  logic               m1_ack,
    output logic               read_m1,
    output cpu_isa_pkg::word_t address1,
    output cpu_isa_pkg::word_t num_inst,
    output cpu_isa_pkg::word_t output_port,
    output logic               is_halted
);

    cpu_ctrl_pkg::ctrl_t       ctrl;
    cpu_isa_pkg::inst_fields_t fields;
    cpu_isa_pkg::word_t        read_data_1;
    cpu_isa_pkg::word_t        read_data_2;
    cpu_isa_pkg::word_t        result;
    logic                      ir_load;
    logic                      exec_en;
    logic                      is_zero;

    ////////////////////////////////////////////////////////////////////
    // Fetch / execute sequencing
    ////////////////////////////////////////////////////////////////////

    cpu_fsm u_fsm (
        .clk       (clk),
        .reset_n   (reset_n),
        .m1_ack    (m1_ack),
        .ctrl      (ctrl),
        .read_m1   (read_m1),
        .ir_load   (ir_load),
        .exec_en   (exec_en),
        .is_halted (is_halted)
    );

    pc_unit #(.RESET_PC(RESET_PC)) u_pc (
        .clk       (clk),
        .reset_n   (reset_n),
        .exec_en   (exec_en),
        .ctrl      (ctrl),
        .fields    (fields),
        .is_zero   (is_zero),
        .pc        (address1),  // PC drives the fetch address
        .num_inst  (num_inst)
    );

    inst_decoder u_decoder (
        .clk       (clk),
        .reset_n   (reset_n),
        .ir_load   (ir_load),
        .data1     (data1),
        .ctrl      (ctrl),
        .fields    (fields)
    );

    ////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////

    arch_state u_arch (
        .clk         (clk),
        .reset_n     (reset_n),
        .exec_en     (exec_en),
        .ctrl        (ctrl),
        .fields      (fields),
        .result      (result),
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2),
        .output_port (output_port)
    );

    alu u_alu (
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2),
        .ctrl        (ctrl),
        .fields      (fields),
        .result      (result),
        .is_zero     (is_zero)
    );

endmodule

//--- source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      ir_load,
    input  cpu_isa_pkg::word_t        data1,
    output cpu_ctrl_pkg::ctrl_t       ctrl,
    output cpu_isa_pkg::inst_fields_t fields
);

    cpu_isa_pkg::inst_fields_t ir;

    // All-zero IR decodes as BNE r0, r0 which never branches
    always_ff @(posedge clk) begin
        if (reset_n) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= cpu_isa_pkg::inst_fields_t'(data1);
        end
    end

    assign fields = ir;

    ////////////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl = '0;  // Unknown encodings fall through as no-ops
        case (ir.opcode)
            cpu_isa_pkg::BNE,
            cpu_isa_pkg::BEQ: begin
                ctrl.alu_op          = cpu_ctrl_pkg::OP_SUB;  // rs - rt drives is_zero
                ctrl.is_branch       = 1'b1;
                ctrl.branch_on_equal = (ir.opcode == cpu_isa_pkg::BEQ);
            end
            cpu_isa_pkg::ADI: begin
                ctrl.alu_op      = cpu_ctrl_pkg::OP_ADD;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            cpu_isa_pkg::ORI: begin
                ctrl.alu_op       = cpu_ctrl_pkg::OP_OR;
                ctrl.alu_src_imm  = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                ctrl.reg_write    = 1'b1;
            end
            cpu_isa_pkg::LHI: begin
                ctrl.alu_op       = cpu_ctrl_pkg::OP_LHI;
                ctrl.alu_src_imm  = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                ctrl.reg_write    = 1'b1;
            end
            cpu_isa_pkg::JMP: ctrl.is_jump = 1'b1;
            cpu_isa_pkg::RTYPE: begin
                ctrl.dest_rd = 1'b1;
                case (ir.funct)
                    cpu_isa_pkg::ADD: ctrl.alu_op = cpu_ctrl_pkg::OP_ADD;
                    cpu_isa_pkg::SUB: ctrl.alu_op = cpu_ctrl_pkg::OP_SUB;
                    cpu_isa_pkg::AND: ctrl.alu_op = cpu_ctrl_pkg::OP_AND;
                    cpu_isa_pkg::ORR: ctrl.alu_op = cpu_ctrl_pkg::OP_OR;
                    cpu_isa_pkg::NOT: ctrl.alu_op = cpu_ctrl_pkg::OP_NOT;
                    cpu_isa_pkg::TCP: ctrl.alu_op = cpu_ctrl_pkg::OP_TCP;
                    cpu_isa_pkg::SHL: ctrl.alu_op = cpu_ctrl_pkg::OP_SHL;
                    cpu_isa_pkg::SHR: ctrl.alu_op = cpu_ctrl_pkg::OP_SHR;
                    default:          ctrl.alu_op = cpu_ctrl_pkg::OP_ADD;
                endcase
                ctrl.reg_write = (ir.funct inside {cpu_isa_pkg::ADD, cpu_isa_pkg::SUB,
                                                   cpu_isa_pkg::AND, cpu_isa_pkg::ORR,
                                                   cpu_isa_pkg::NOT, cpu_isa_pkg::TCP,
                                                   cpu_isa_pkg::SHL, cpu_isa_pkg::SHR});
                ctrl.is_wwd    = (ir.funct == cpu_isa_pkg::WWD);
                ctrl.is_halt   = (ir.funct == cpu_isa_pkg::HLT);
            end
            default: ctrl = '0;
        endcase
    end

endmodule

//--- source/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
    parameter cpu_isa_pkg::word_t RESET_PC = 16'h0000
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      exec_en,
    input  cpu_ctrl_pkg::ctrl_t       ctrl,
    input  cpu_isa_pkg::inst_fields_t fields,
    input  logic                      is_zero,
    output cpu_isa_pkg::word_t        pc,
    output cpu_isa_pkg::word_t        num_inst
);

    cpu_isa_pkg::word_t pc_plus1;
    cpu_isa_pkg::word_t branch_target;
    cpu_isa_pkg::word_t jump_target;
    cpu_isa_pkg::word_t next_pc;
    logic               taken;

    assign pc_plus1      = pc + 16'd1;
    assign branch_target = pc_plus1 + {{8{fields[7]}}, fields[7:0]};
    assign jump_target   = {pc[15:12], fields[11:0]};  // Stays in the current 4K page

    // BEQ takes on zero, BNE on non-zero
    assign taken = ctrl.is_branch && (is_zero == ctrl.branch_on_equal);

    always_comb begin
        if (ctrl.is_jump) begin
            next_pc = jump_target;
        end else if (taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc       <= RESET_PC;
            num_inst <= '0;
        end else if (exec_en) begin
            pc       <= next_pc;
            num_inst <= num_inst + 16'd1;  // HLT and no-ops count too
        end
    end

endmodule

//--- sources.f
source/cpu_isa_pkg.sv
source/cpu_ctrl_pkg.sv
source/cpu_fsm.sv
source/pc_unit.sv
source/inst_decoder.sv
source/arch_state.sv
source/alu.sv
source/cpu_top.sv
dv/inst_memory_model.sv
dv/cpu_tb.sv
